//--- Bender.yml
package:
  name: conbus_sys

sources:
  # package first, then rtl bottom up
  - files:
      - source/conbus_pkg.sv
      - source/conbus_arb2.sv
      - source/conbus2x5.sv
      - source/wb_bram.sv
      - source/wb_sysctl.sv
      - source/conbus_sys.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/conbus_sys_props.sv
      - tests/tb_conbus_sys.sv

//--- conbus_sys.f
+incdir+include
source/conbus_pkg.sv
source/conbus_arb2.sv
source/conbus2x5.sv
source/wb_bram.sv
source/wb_sysctl.sv
source/conbus_sys.sv
tests/conbus_sys_props.sv
tests/tb_conbus_sys.sv

//--- source/conbus2x5.sv
// two-master five-slave wishbone shared bus with arbiter, address decode and data return mux
`timescale 1ns/100ps

module conbus2x5 (
	input  logic                         sys_clk,
	input  logic                         rst_i,
	input  conbus_pkg::arb_mode_e        arb_mode_i,

	// master 0
	input  logic [conbus_pkg::DAT_W-1:0] m0_dat_i,
	output logic [conbus_pkg::DAT_W-1:0] m0_dat_o,
	input  logic [conbus_pkg::ADR_W-1:0] m0_adr_i,
	input  logic [conbus_pkg::CTI_W-1:0] m0_cti_i,
	input  logic [conbus_pkg::SEL_W-1:0] m0_sel_i,
	input  logic                         m0_we_i,
	input  logic                         m0_cyc_i,
	input  logic                         m0_stb_i,
	output logic                         m0_ack_o,

	// master 1
	input  logic [conbus_pkg::DAT_W-1:0] m1_dat_i,
	output logic [conbus_pkg::DAT_W-1:0] m1_dat_o,
	input  logic [conbus_pkg::ADR_W-1:0] m1_adr_i,
	input  logic [conbus_pkg::CTI_W-1:0] m1_cti_i,
	input  logic [conbus_pkg::SEL_W-1:0] m1_sel_i,
	input  logic                         m1_we_i,
	input  logic                         m1_cyc_i,
	input  logic                         m1_stb_i,
	output logic                         m1_ack_o,

	// slave 0
	input  logic [conbus_pkg::DAT_W-1:0] s0_dat_i,
	output logic [conbus_pkg::DAT_W-1:0] s0_dat_o,
	output logic [conbus_pkg::ADR_W-1:0] s0_adr_o,
	output logic [conbus_pkg::CTI_W-1:0] s0_cti_o,
	output logic [conbus_pkg::SEL_W-1:0] s0_sel_o,
	output logic                         s0_we_o,
	output logic                         s0_cyc_o,
	output logic                         s0_stb_o,
	input  logic                         s0_ack_i,

	// slave 1
	input  logic [conbus_pkg::DAT_W-1:0] s1_dat_i,
	output logic [conbus_pkg::DAT_W-1:0] s1_dat_o,
	output logic [conbus_pkg::ADR_W-1:0] s1_adr_o,
	output logic [conbus_pkg::CTI_W-1:0] s1_cti_o,
	output logic [conbus_pkg::SEL_W-1:0] s1_sel_o,
	output logic                         s1_we_o,
	output logic                         s1_cyc_o,
	output logic                         s1_stb_o,
	input  logic                         s1_ack_i,

	// slave 2
	input  logic [conbus_pkg::DAT_W-1:0] s2_dat_i,
	output logic [conbus_pkg::DAT_W-1:0] s2_dat_o,
	output logic [conbus_pkg::ADR_W-1:0] s2_adr_o,
	output logic [conbus_pkg::CTI_W-1:0] s2_cti_o,
	output logic [conbus_pkg::SEL_W-1:0] s2_sel_o,
	output logic                         s2_we_o,
	output logic                         s2_cyc_o,
	output logic                         s2_stb_o,
	input  logic                         s2_ack_i,

	// slave 3
	input  logic [conbus_pkg::DAT_W-1:0] s3_dat_i,
	output logic [conbus_pkg::DAT_W-1:0] s3_dat_o,
	output logic [conbus_pkg::ADR_W-1:0] s3_adr_o,
	output logic [conbus_pkg::CTI_W-1:0] s3_cti_o,
	output logic [conbus_pkg::SEL_W-1:0] s3_sel_o,
	output logic                         s3_we_o,
	output logic                         s3_cyc_o,
	output logic                         s3_stb_o,
	input  logic                         s3_ack_i,

	// slave 4
	input  logic [conbus_pkg::DAT_W-1:0] s4_dat_i,
	output logic [conbus_pkg::DAT_W-1:0] s4_dat_o,
	output logic [conbus_pkg::ADR_W-1:0] s4_adr_o,
	output logic [conbus_pkg::CTI_W-1:0] s4_cti_o,
	output logic [conbus_pkg::SEL_W-1:0] s4_sel_o,
	output logic                         s4_we_o,
	output logic                         s4_cyc_o,
	output logic                         s4_stb_o,
	input  logic                         s4_ack_i
);

	conbus_pkg::arb_gnt_e gnt;
	logic gnt_m1;

	// granted master, shared by all slaves
	logic [conbus_pkg::ADR_W-1:0] i_adr;
	logic [conbus_pkg::CTI_W-1:0] i_cti;
	logic [conbus_pkg::SEL_W-1:0] i_sel;
	logic [conbus_pkg::DAT_W-1:0] i_dat;
	logic i_we;
	logic i_cyc;
	logic i_stb;

	// slave side return path
	logic [4:0] slave_sel;
	logic [4:0] slave_sel_q;
	logic [conbus_pkg::DAT_W-1:0] i_dat_s;
	logic i_ack;

	conbus_arb2 u_arb (
		.sys_clk (sys_clk),
		.rst_i   (rst_i),
		.req_i   ({m1_cyc_i, m0_cyc_i}),
		.mode_i  (arb_mode_i),
		.gnt_o   (gnt)
	);

	assign gnt_m1 = (gnt == conbus_pkg::GNT_M1);

	// master mux
	assign i_adr = gnt_m1 ? m1_adr_i : m0_adr_i;
	assign i_cti = gnt_m1 ? m1_cti_i : m0_cti_i;
	assign i_sel = gnt_m1 ? m1_sel_i : m0_sel_i;
	assign i_dat = gnt_m1 ? m1_dat_i : m0_dat_i;
	assign i_we  = gnt_m1 ? m1_we_i  : m0_we_i;
	assign i_cyc = gnt_m1 ? m1_cyc_i : m0_cyc_i;
	assign i_stb = gnt_m1 ? m1_stb_i : m0_stb_i;

	// decode, windows never overlap so at most one bit is set
	assign slave_sel[0] = (i_adr[conbus_pkg::ADR_W-1 -: 3] == conbus_pkg::S0_ADDR);
	assign slave_sel[1] = (i_adr[conbus_pkg::ADR_W-1 -: 3] == conbus_pkg::S1_ADDR);
	assign slave_sel[2] = (i_adr[conbus_pkg::ADR_W-1 -: 2] == conbus_pkg::S2_ADDR);
	assign slave_sel[3] = (i_adr[conbus_pkg::ADR_W-1 -: 2] == conbus_pkg::S3_ADDR);
	assign slave_sel[4] = (i_adr[conbus_pkg::ADR_W-1 -: 2] == conbus_pkg::S4_ADDR);

	// broadcast, cyc only to the decoded slave
	assign {s0_adr_o, s0_cti_o, s0_sel_o, s0_dat_o, s0_we_o, s0_stb_o}
		= {i_adr, i_cti, i_sel, i_dat, i_we, i_stb};
	assign s0_cyc_o = i_cyc & slave_sel[0];
	assign {s1_adr_o, s1_cti_o, s1_sel_o, s1_dat_o, s1_we_o, s1_stb_o}
		= {i_adr, i_cti, i_sel, i_dat, i_we, i_stb};
	assign s1_cyc_o = i_cyc & slave_sel[1];
	assign {s2_adr_o, s2_cti_o, s2_sel_o, s2_dat_o, s2_we_o, s2_stb_o}
		= {i_adr, i_cti, i_sel, i_dat, i_we, i_stb};
	assign s2_cyc_o = i_cyc & slave_sel[2];
	assign {s3_adr_o, s3_cti_o, s3_sel_o, s3_dat_o, s3_we_o, s3_stb_o}
		= {i_adr, i_cti, i_sel, i_dat, i_we, i_stb};
	assign s3_cyc_o = i_cyc & slave_sel[3];
	assign {s4_adr_o, s4_cti_o, s4_sel_o, s4_dat_o, s4_we_o, s4_stb_o}
		= {i_adr, i_cti, i_sel, i_dat, i_we, i_stb};
	assign s4_cyc_o = i_cyc & slave_sel[4];

	// select one cycle late, lines up with the slave ack
	always_ff @(posedge sys_clk) begin
		if (rst_i) begin
			slave_sel_q <= '0;
		end else begin
			slave_sel_q <= slave_sel;
		end
	end

	assign i_dat_s = ({conbus_pkg::DAT_W{slave_sel_q[0]}} & s0_dat_i)
		| ({conbus_pkg::DAT_W{slave_sel_q[1]}} & s1_dat_i)
		| ({conbus_pkg::DAT_W{slave_sel_q[2]}} & s2_dat_i)
		| ({conbus_pkg::DAT_W{slave_sel_q[3]}} & s3_dat_i)
		| ({conbus_pkg::DAT_W{slave_sel_q[4]}} & s4_dat_i);

	assign i_ack = s0_ack_i | s1_ack_i | s2_ack_i | s3_ack_i | s4_ack_i;

	// data to both, ack only to the owner
	assign m0_dat_o = i_dat_s;
	assign m1_dat_o = i_dat_s;
	assign m0_ack_o = i_ack & ~gnt_m1;
	assign m1_ack_o = i_ack & gnt_m1;

endmodule

//--- source/conbus_arb2.sv
// two-master bus arbiter with registered grant, instantiated by the shared-bus interconnect
`timescale 1ns/100ps

module conbus_arb2 (
	input  logic                  sys_clk,
	input  logic                  rst_i,
	input  logic [1:0]            req_i,
	input  conbus_pkg::arb_mode_e mode_i,
	output conbus_pkg::arb_gnt_e  gnt_o
);

	conbus_pkg::arb_gnt_e gnt_q;
	conbus_pkg::arb_gnt_e gnt_d;
	conbus_pkg::arb_gnt_e other;
	logic own_req;
	logic other_req;
	// holder had the bus last cycle
	logic held_q;

	assign other = (gnt_q == conbus_pkg::GNT_M0) ? conbus_pkg::GNT_M1 : conbus_pkg::GNT_M0;
	assign own_req = (gnt_q == conbus_pkg::GNT_M1) ? req_i[1] : req_i[0];
	assign other_req = (gnt_q == conbus_pkg::GNT_M1) ? req_i[0] : req_i[1];

	always_comb begin
		gnt_d = gnt_q;
		// grant only moves once the holder lets go of cyc
		if (!own_req) begin
			if (mode_i == conbus_pkg::ARB_FIXED_M0) begin
				// m0 wins, park on m0 when idle
				gnt_d = (req_i[1] && !req_i[0]) ? conbus_pkg::GNT_M1 : conbus_pkg::GNT_M0;
			end else if (other_req || held_q) begin
				// round robin, hand over or park on the one that did not hold
				gnt_d = other;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rst_i) begin
			gnt_q  <= conbus_pkg::GNT_M0;
			held_q <= 1'b0;
		end else begin
			gnt_q  <= gnt_d;
			held_q <= own_req;
		end
	end

	assign gnt_o = gnt_q;

endmodule

//--- source/conbus_pkg.sv
// shared bus widths, address map, control registers and arbiter types, used by scoped name
package conbus_pkg;

	// wishbone bus widths
	localparam int ADR_W = 32;
	localparam int DAT_W = 32;
	localparam int SEL_W = 4;
	localparam int CTI_W = 3;

	// slave windows on the top address bits
	// s0 and s1 split the lowest quarter on bit 29
	localparam logic [2:0] S0_ADDR = 3'b000;
	localparam logic [2:0] S1_ADDR = 3'b001;
	// remaining quarters, compared on bits 31:30
	localparam logic [1:0] S2_ADDR = 2'b01;
	localparam logic [1:0] S3_ADDR = 2'b10;
	localparam logic [1:0] S4_ADDR = 2'b11;

	// block ram word address, taken from adr[9:2]
	localparam int BRAM_AW = 8;

	// control block contents
	localparam logic [DAT_W-1:0] SYSCTL_ID = 32'hc0b5_2f05;

	// register word offsets, decoded from adr[3:2]
	localparam logic [1:0] REG_ID       = 2'd0;
	localparam logic [1:0] REG_ARB_MODE = 2'd1;
	localparam logic [1:0] REG_SCRATCH  = 2'd2;

	// arbiter policy, held in the control block
	typedef enum logic {
		ARB_ROUND_ROBIN = 1'b0,
		ARB_FIXED_M0    = 1'b1
	} arb_mode_e;

	// current bus owner
	typedef enum logic {
		GNT_M0 = 1'b0,
		GNT_M1 = 1'b1
	} arb_gnt_e;

endpackage

//--- source/conbus_sys.sv
// top level wishbone system, two outside masters on the shared bus with four rams and sysctl
`timescale 1ns/100ps

module conbus_sys (
	input  logic                         sys_clk,
	input  logic                         rst_i,
	// master 0
	input  logic [conbus_pkg::DAT_W-1:0] m0_dat_i,
	output logic [conbus_pkg::DAT_W-1:0] m0_dat_o,
	input  logic [conbus_pkg::ADR_W-1:0] m0_adr_i,
	input  logic [conbus_pkg::CTI_W-1:0] m0_cti_i,
	input  logic [conbus_pkg::SEL_W-1:0] m0_sel_i,
	input  logic                         m0_we_i,
	input  logic                         m0_cyc_i,
	input  logic                         m0_stb_i,
	output logic                         m0_ack_o,
	// master 1
	input  logic [conbus_pkg::DAT_W-1:0] m1_dat_i,
	output logic [conbus_pkg::DAT_W-1:0] m1_dat_o,
	input  logic [conbus_pkg::ADR_W-1:0] m1_adr_i,
	input  logic [conbus_pkg::CTI_W-1:0] m1_cti_i,
	input  logic [conbus_pkg::SEL_W-1:0] m1_sel_i,
	input  logic                         m1_we_i,
	input  logic                         m1_cyc_i,
	input  logic                         m1_stb_i,
	output logic                         m1_ack_o
);

	// slave side wires, index is the slave port
	logic [conbus_pkg::DAT_W-1:0] s_dat_w [5];
	logic [conbus_pkg::DAT_W-1:0] s_dat_r [5];
	logic [conbus_pkg::ADR_W-1:0] s_adr [5];
	logic [conbus_pkg::SEL_W-1:0] s_sel [5];
	logic s_we [5];
	logic s_cyc [5];
	logic s_stb [5];
	logic s_ack [5];
	conbus_pkg::arb_mode_e arb_mode;

	// cti is not used by these slaves, left open
	conbus2x5 u_conbus (
		.sys_clk(sys_clk), .rst_i(rst_i), .arb_mode_i(arb_mode),
		.m0_dat_i(m0_dat_i), .m0_dat_o(m0_dat_o), .m0_adr_i(m0_adr_i), .m0_cti_i(m0_cti_i),
		.m0_sel_i(m0_sel_i), .m0_we_i(m0_we_i), .m0_cyc_i(m0_cyc_i), .m0_stb_i(m0_stb_i),
		.m0_ack_o(m0_ack_o),
		.m1_dat_i(m1_dat_i), .m1_dat_o(m1_dat_o), .m1_adr_i(m1_adr_i), .m1_cti_i(m1_cti_i),
		.m1_sel_i(m1_sel_i), .m1_we_i(m1_we_i), .m1_cyc_i(m1_cyc_i), .m1_stb_i(m1_stb_i),
		.m1_ack_o(m1_ack_o),
		.s0_dat_i(s_dat_r[0]), .s0_dat_o(s_dat_w[0]), .s0_adr_o(s_adr[0]), .s0_cti_o(),
		.s0_sel_o(s_sel[0]), .s0_we_o(s_we[0]), .s0_cyc_o(s_cyc[0]), .s0_stb_o(s_stb[0]),
		.s0_ack_i(s_ack[0]),
		.s1_dat_i(s_dat_r[1]), .s1_dat_o(s_dat_w[1]), .s1_adr_o(s_adr[1]), .s1_cti_o(),
		.s1_sel_o(s_sel[1]), .s1_we_o(s_we[1]), .s1_cyc_o(s_cyc[1]), .s1_stb_o(s_stb[1]),
		.s1_ack_i(s_ack[1]),
		.s2_dat_i(s_dat_r[2]), .s2_dat_o(s_dat_w[2]), .s2_adr_o(s_adr[2]), .s2_cti_o(),
		.s2_sel_o(s_sel[2]), .s2_we_o(s_we[2]), .s2_cyc_o(s_cyc[2]), .s2_stb_o(s_stb[2]),
		.s2_ack_i(s_ack[2]),
		.s3_dat_i(s_dat_r[3]), .s3_dat_o(s_dat_w[3]), .s3_adr_o(s_adr[3]), .s3_cti_o(),
		.s3_sel_o(s_sel[3]), .s3_we_o(s_we[3]), .s3_cyc_o(s_cyc[3]), .s3_stb_o(s_stb[3]),
		.s3_ack_i(s_ack[3]),
		.s4_dat_i(s_dat_r[4]), .s4_dat_o(s_dat_w[4]), .s4_adr_o(s_adr[4]), .s4_cti_o(),
		.s4_sel_o(s_sel[4]), .s4_we_o(s_we[4]), .s4_cyc_o(s_cyc[4]), .s4_stb_o(s_stb[4]),
		.s4_ack_i(s_ack[4])
	);

	wb_bram u_ram0 (
		.sys_clk(sys_clk), .rst_i(rst_i), .wb_adr_i(s_adr[0]), .wb_dat_i(s_dat_w[0]),
		.wb_sel_i(s_sel[0]), .wb_we_i(s_we[0]), .wb_cyc_i(s_cyc[0]), .wb_stb_i(s_stb[0]),
		.wb_dat_o(s_dat_r[0]), .wb_ack_o(s_ack[0])
	);
	wb_bram u_ram1 (
		.sys_clk(sys_clk), .rst_i(rst_i), .wb_adr_i(s_adr[1]), .wb_dat_i(s_dat_w[1]),
		.wb_sel_i(s_sel[1]), .wb_we_i(s_we[1]), .wb_cyc_i(s_cyc[1]), .wb_stb_i(s_stb[1]),
		.wb_dat_o(s_dat_r[1]), .wb_ack_o(s_ack[1])
	);
	wb_bram u_ram2 (
		.sys_clk(sys_clk), .rst_i(rst_i), .wb_adr_i(s_adr[2]), .wb_dat_i(s_dat_w[2]),
		.wb_sel_i(s_sel[2]), .wb_we_i(s_we[2]), .wb_cyc_i(s_cyc[2]), .wb_stb_i(s_stb[2]),
		.wb_dat_o(s_dat_r[2]), .wb_ack_o(s_ack[2])
	);
	wb_bram u_ram3 (
		.sys_clk(sys_clk), .rst_i(rst_i), .wb_adr_i(s_adr[3]), .wb_dat_i(s_dat_w[3]),
		.wb_sel_i(s_sel[3]), .wb_we_i(s_we[3]), .wb_cyc_i(s_cyc[3]), .wb_stb_i(s_stb[3]),
		.wb_dat_o(s_dat_r[3]), .wb_ack_o(s_ack[3])
	);

	// control block drives the arbiter policy
	wb_sysctl u_sysctl (
		.sys_clk(sys_clk), .rst_i(rst_i), .wb_adr_i(s_adr[4]), .wb_dat_i(s_dat_w[4]),
		.wb_sel_i(s_sel[4]), .wb_we_i(s_we[4]), .wb_cyc_i(s_cyc[4]), .wb_stb_i(s_stb[4]),
		.wb_dat_o(s_dat_r[4]), .wb_ack_o(s_ack[4]), .arb_mode_o(arb_mode)
	);

endmodule

//--- source/wb_bram.sv
// single-port wishbone block ram with byte selects, one memory per slave window
`timescale 1ns/100ps

module wb_bram (
	input  logic                         sys_clk,
	input  logic                         rst_i,
	input  logic [conbus_pkg::ADR_W-1:0] wb_adr_i,
	input  logic [conbus_pkg::DAT_W-1:0] wb_dat_i,
	input  logic [conbus_pkg::SEL_W-1:0] wb_sel_i,
	input  logic                         wb_we_i,
	input  logic                         wb_cyc_i,
	input  logic                         wb_stb_i,
	output logic [conbus_pkg::DAT_W-1:0] wb_dat_o,
	output logic                         wb_ack_o
);

	logic [conbus_pkg::DAT_W-1:0] mem [2**conbus_pkg::BRAM_AW];
	logic [conbus_pkg::BRAM_AW-1:0] word_adr;
	logic access;

	// word index, byte offset bits dropped
	assign word_adr = wb_adr_i[conbus_pkg::BRAM_AW+1:2];

	// first cycle of a strobe, not the ack cycle
	assign access = wb_cyc_i & wb_stb_i & ~wb_ack_o;

	// ack one cycle after strobe, low again after
	always_ff @(posedge sys_clk) begin
		if (rst_i) begin
			wb_ack_o <= 1'b0;
		end else begin
			wb_ack_o <= access;
		end
	end

	// write per byte lane
	always_ff @(posedge sys_clk) begin
		if (access && wb_we_i) begin
			for (int b = 0; b < conbus_pkg::SEL_W; b++) begin
				if (wb_sel_i[b]) begin
					mem[word_adr][8*b +: 8] <= wb_dat_i[8*b +: 8];
				end
			end
		end
	end

	// registered read, old contents on a write
	always_ff @(posedge sys_clk) begin
		if (access) begin
			wb_dat_o <= mem[word_adr];
		end
	end

endmodule

//--- source/wb_sysctl.sv
// wishbone system-control registers, id word, arbiter mode and scratch, on slave port 4
`timescale 1ns/100ps

module wb_sysctl (
	input  logic                         sys_clk,
	input  logic                         rst_i,
	input  logic [conbus_pkg::ADR_W-1:0] wb_adr_i,
	input  logic [conbus_pkg::DAT_W-1:0] wb_dat_i,
	input  logic [conbus_pkg::SEL_W-1:0] wb_sel_i,
	input  logic                         wb_we_i,
	input  logic                         wb_cyc_i,
	input  logic                         wb_stb_i,
	output logic [conbus_pkg::DAT_W-1:0] wb_dat_o,
	output logic                         wb_ack_o,
	output conbus_pkg::arb_mode_e        arb_mode_o
);

	conbus_pkg::arb_mode_e mode_q;
	logic [conbus_pkg::DAT_W-1:0] scratch_q;
	logic [1:0] reg_sel;
	logic access;
	logic wr;

	assign reg_sel = wb_adr_i[3:2];
	assign access = wb_cyc_i & wb_stb_i & ~wb_ack_o;
	// whole-word writes only, partial lanes dropped
	assign wr = access & wb_we_i & (&wb_sel_i);

	always_ff @(posedge sys_clk) begin
		if (rst_i) begin
			wb_ack_o <= 1'b0;
			mode_q   <= conbus_pkg::ARB_ROUND_ROBIN;
		end else begin
			wb_ack_o <= access;
			// mode in bit 0
			if (wr && reg_sel == conbus_pkg::REG_ARB_MODE) begin
				mode_q <= conbus_pkg::arb_mode_e'(wb_dat_i[0]);
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (wr && reg_sel == conbus_pkg::REG_SCRATCH) begin
			scratch_q <= wb_dat_i;
		end
	end

	// read mux, registered into the ack cycle
	always_ff @(posedge sys_clk) begin
		if (access) begin
			case (reg_sel)
				conbus_pkg::REG_ID:       wb_dat_o <= conbus_pkg::SYSCTL_ID;
				conbus_pkg::REG_ARB_MODE: wb_dat_o <= {{(conbus_pkg::DAT_W-1){1'b0}}, mode_q};
				conbus_pkg::REG_SCRATCH:  wb_dat_o <= scratch_q;
				default:                  wb_dat_o <= '0;
			endcase
		end
	end

	assign arb_mode_o = mode_q;

endmodule

//--- tests/conbus_sys_props.sv
// wishbone protocol assertions for the shared bus, bound into every conbus2x5 instance
`timescale 1ns/100ps

module conbus_sys_props (
	input logic       sys_clk,
	input logic       rst_i,
	input logic       m0_cyc_i,
	input logic       m1_cyc_i,
	input logic       m0_ack_o,
	input logic       m1_ack_o,
	input logic       gnt_m1,
	input logic [4:0] s_cyc
);

	// ack only while the master holds cyc
	m0_ack_in_cyc: assert property (@(posedge sys_clk) disable iff (rst_i) m0_ack_o |-> m0_cyc_i)
		else $error("ack on master 0 while its cyc is low");
	m1_ack_in_cyc: assert property (@(posedge sys_clk) disable iff (rst_i) m1_ack_o |-> m1_cyc_i)
		else $error("ack on master 1 while its cyc is low");

	one_master_ack: assert property (@(posedge sys_clk) disable iff (rst_i) !(m0_ack_o && m1_ack_o))
		else $error("both master acks high together");

	// decode windows are disjoint
	one_slave_cyc: assert property (@(posedge sys_clk) disable iff (rst_i) $onehot0(s_cyc))
		else $error("more than one slave cyc high");

	// holder is the previous grant
	grant_on_release: assert property (@(posedge sys_clk) disable iff (rst_i)
		(gnt_m1 != $past(gnt_m1)) |-> !$past(gnt_m1 ? m1_cyc_i : m0_cyc_i))
		else $error("grant moved while the holder kept cyc high");

endmodule

bind conbus2x5 conbus_sys_props u_props (
	.sys_clk  (sys_clk),
	.rst_i    (rst_i),
	.m0_cyc_i (m0_cyc_i),
	.m1_cyc_i (m1_cyc_i),
	.m0_ack_o (m0_ack_o),
	.m1_ack_o (m1_ack_o),
	.gnt_m1   (gnt_m1),
	.s_cyc    ({s4_cyc_o, s3_cyc_o, s2_cyc_o, s1_cyc_o, s0_cyc_o})
);

//--- include/wb_master_tasks.svh
// wishbone master bus-cycle tasks, included in the testbench that declares sys_clk and m0_/m1_ signals
`ifndef WB_MASTER_TASKS_SVH
`define WB_MASTER_TASKS_SVH

// set one master port, stb follows cyc
task automatic wb_drive(input bit port, input logic cyc, input logic we,
	input logic [conbus_pkg::ADR_W-1:0] adr, input logic [conbus_pkg::DAT_W-1:0] dat,
	input logic [conbus_pkg::SEL_W-1:0] sel);
	if (!port) begin
		{m0_cyc, m0_stb, m0_we, m0_cti} = {cyc, cyc, we, 3'b000};
		{m0_adr, m0_dat_w, m0_sel} = {adr, dat, sel};
	end else begin
		{m1_cyc, m1_stb, m1_we, m1_cti} = {cyc, cyc, we, 3'b000};
		{m1_adr, m1_dat_w, m1_sel} = {adr, dat, sel};
	end
endtask

// ack sampled mid-cycle, returns 10 ns after the next edge
task automatic wb_wait_ack(input bit port, output logic [conbus_pkg::DAT_W-1:0] dat);
	do @(negedge sys_clk); while (!(port ? m1_ack : m0_ack));
	dat = port ? m1_dat_r : m0_dat_r;
	@(posedge sys_clk);
	#10;
endtask

task automatic wb_write(input bit port, input logic [conbus_pkg::ADR_W-1:0] adr,
	input logic [conbus_pkg::DAT_W-1:0] dat, input logic [conbus_pkg::SEL_W-1:0] sel);
	logic [conbus_pkg::DAT_W-1:0] ignored;
	wb_drive(port, 1'b1, 1'b1, adr, dat, sel);
	wb_wait_ack(port, ignored);
	wb_drive(port, 1'b0, 1'b0, '0, '0, '0);
endtask

task automatic wb_read(input bit port, input logic [conbus_pkg::ADR_W-1:0] adr,
	output logic [conbus_pkg::DAT_W-1:0] dat);
	wb_drive(port, 1'b1, 1'b0, adr, '0, '1);
	wb_wait_ack(port, dat);
	wb_drive(port, 1'b0, 1'b0, '0, '0, '0);
endtask

// release the port for n cycles
task automatic wb_idle(input bit port, input int n);
	wb_drive(port, 1'b0, 1'b0, '0, '0, '0);
	repeat (n) begin
		@(posedge sys_clk);
		#10;
	end
endtask

`endif

//--- tests/tb_conbus_sys.sv
// testbench for conbus_sys, drives both master ports and checks every ack against a reference model
`timescale 1ns/100ps

module tb_conbus_sys;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 16;
	localparam int MEM_OPS = 24;
	localparam int CONC_OPS = 12;
	localparam int FIXED_ROUNDS = 3;
	// accesses over all tests, sets the watchdog
	localparam int PLANNED = 3 * MEM_OPS + 8 + 9 + 4 * CONC_OPS + 1 + 3 * FIXED_ROUNDS + 8;

	logic sys_clk;
	logic rst_i;
	logic [conbus_pkg::DAT_W-1:0] m0_dat_w;
	logic [conbus_pkg::DAT_W-1:0] m0_dat_r;
	logic [conbus_pkg::ADR_W-1:0] m0_adr;
	logic [conbus_pkg::CTI_W-1:0] m0_cti;
	logic [conbus_pkg::SEL_W-1:0] m0_sel;
	logic m0_we;
	logic m0_cyc;
	logic m0_stb;
	logic m0_ack;
	logic [conbus_pkg::DAT_W-1:0] m1_dat_w;
	logic [conbus_pkg::DAT_W-1:0] m1_dat_r;
	logic [conbus_pkg::ADR_W-1:0] m1_adr;
	logic [conbus_pkg::CTI_W-1:0] m1_cti;
	logic [conbus_pkg::SEL_W-1:0] m1_sel;
	logic m1_we;
	logic m1_cyc;
	logic m1_stb;
	logic m1_ack;

	// reference model, four rams and the control registers
	logic [31:0] ref_mem [4][256];
	bit ref_written [4][256];
	logic ref_mode;
	logic [31:0] ref_scratch;

	// pending accesses, one entry per expected ack
	bit q_port[$];
	bit q_rd[$];
	logic [31:0] q_dat[$];
	string q_name[$];
	bit ack_order[$];
	bit last_owner;
	string test_name;
	integer seed;

	// concurrent test stimulus, drawn before the fork
	logic [7:0] c_word [2][CONC_OPS];
	logic [31:0] c_dat [2][CONC_OPS];
	logic [3:0] c_sel [2][CONC_OPS];

	conbus_sys i_conbus_sys (
		.sys_clk(sys_clk), .rst_i(rst_i),
		.m0_dat_i(m0_dat_w), .m0_dat_o(m0_dat_r), .m0_adr_i(m0_adr), .m0_cti_i(m0_cti),
		.m0_sel_i(m0_sel), .m0_we_i(m0_we), .m0_cyc_i(m0_cyc), .m0_stb_i(m0_stb),
		.m0_ack_o(m0_ack),
		.m1_dat_i(m1_dat_w), .m1_dat_o(m1_dat_r), .m1_adr_i(m1_adr), .m1_cti_i(m1_cti),
		.m1_sel_i(m1_sel), .m1_we_i(m1_we), .m1_cyc_i(m1_cyc), .m1_stb_i(m1_stb),
		.m1_ack_o(m1_ack)
	);

	`include "wb_master_tasks.svh"

	always #(CLK_PERIOD / 2) sys_clk = ~sys_clk;

	task automatic stop_run();
		$display("test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic show_problem(input string msg);
		$display("%s", msg);
		stop_run();
	endtask

	task automatic show_mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("** Error %s: expected 0x%08h, actual 0x%08h", name, exp, act);
		stop_run();
	endtask

	// next value of the seeded sequence
	function automatic logic [31:0] rand32();
		return $random(seed);
	endfunction

	// slave index from the top address bits
	function automatic int slave_of(input logic [31:0] adr);
		if (adr[31:29] == conbus_pkg::S0_ADDR) return 0;
		if (adr[31:29] == conbus_pkg::S1_ADDR) return 1;
		if (adr[31:30] == conbus_pkg::S2_ADDR) return 2;
		if (adr[31:30] == conbus_pkg::S3_ADDR) return 3;
		return 4;
	endfunction

	// bits 28:10 carry don't-care filler
	function automatic logic [31:0] mem_addr(input int s, input logic [7:0] word,
		input logic [18:0] mid);
		logic [31:0] base;
		case (s)
			0: base = {conbus_pkg::S0_ADDR, 29'b0};
			1: base = {conbus_pkg::S1_ADDR, 29'b0};
			2: base = {conbus_pkg::S2_ADDR, 30'b0};
			3: base = {conbus_pkg::S3_ADDR, 30'b0};
			default: base = {conbus_pkg::S4_ADDR, 30'b0};
		endcase
		return base | {3'b0, mid, word, 2'b00};
	endfunction

	function automatic logic [31:0] ref_read(input logic [31:0] adr);
		int s;
		s = slave_of(adr);
		if (s < 4) return ref_mem[s][adr[9:2]];
		case (adr[3:2])
			conbus_pkg::REG_ID: return conbus_pkg::SYSCTL_ID;
			conbus_pkg::REG_ARB_MODE: return {31'b0, ref_mode};
			conbus_pkg::REG_SCRATCH: return ref_scratch;
			default: return '0;
		endcase
	endfunction

	task automatic ref_write(input logic [31:0] adr, input logic [31:0] dat, input logic [3:0] sel);
		int s;
		s = slave_of(adr);
		if (s < 4) begin
			for (int b = 0; b < 4; b++) begin
				if (sel[b]) ref_mem[s][adr[9:2]][8*b +: 8] = dat[8*b +: 8];
			end
			// a word is known once all four lanes were written
			ref_written[s][adr[9:2]] = ref_written[s][adr[9:2]] | (sel == 4'hf);
		end else if (sel == 4'hf) begin
			// id register ignores writes
			if (adr[3:2] == conbus_pkg::REG_ARB_MODE) ref_mode = dat[0];
			if (adr[3:2] == conbus_pkg::REG_SCRATCH) ref_scratch = dat;
		end
	endtask

	// master that the mode rule grants first when both ask from idle
	function automatic bit first_grant(input logic mode, input bit last);
		if (mode == conbus_pkg::ARB_FIXED_M0) return 1'b0;
		return ~last;
	endfunction

	task automatic expect_access(input bit port, input bit rd, input logic [31:0] dat);
		q_port.push_back(port);
		q_rd.push_back(rd);
		q_dat.push_back(dat);
		q_name.push_back(test_name);
	endtask

	task automatic bus_write(input bit port, input logic [31:0] adr, input logic [31:0] dat,
		input logic [3:0] sel);
		expect_access(port, 1'b0, '0);
		ref_write(adr, dat, sel);
		wb_write(port, adr, dat, sel);
	endtask

	task automatic bus_read(input bit port, input logic [31:0] adr);
		logic [31:0] got;
		expect_access(port, 1'b1, ref_read(adr));
		wb_read(port, adr, got);
	endtask

	// match an ack to the oldest pending access of that port
	task automatic check_ack(input bit port, input logic [31:0] got);
		int idx;
		idx = -1;
		for (int i = 0; i < q_port.size(); i++) begin
			if (idx < 0 && q_port[i] == port) idx = i;
		end
		assert (idx >= 0) else show_problem($sformatf("ack on m%0d with no access pending", port));
		if (idx >= 0) begin
			if (q_rd[idx]) begin
				assert (got === q_dat[idx]) else show_mismatch(q_name[idx], q_dat[idx], got);
			end
			ack_order.push_back(port);
			q_port.delete(idx);
			q_rd.delete(idx);
			q_dat.delete(idx);
			q_name.delete(idx);
		end
	endtask

	// ack and read data are stable mid-cycle
	always @(negedge sys_clk) begin
		if (m0_ack) check_ack(1'b0, m0_dat_r);
		if (m1_ack) check_ack(1'b1, m1_dat_r);
	end

	task automatic memory_readback();
		int s;
		logic [31:0] r;
		logic [31:0] adr;
		test_name = "memories";
		for (int i = 0; i < MEM_OPS; i++) begin
			s = i % 4;
			r = rand32();
			adr = mem_addr(s, r[7:0], r[26:8]);
			// seed the word whole before splitting lanes
			if (!ref_written[s][r[7:0]]) bus_write(1'b0, adr, rand32(), 4'hf);
			bus_write(1'b0, adr, rand32(), r[30:27]);
			bus_read(1'b0, adr);
		end
	endtask

	task automatic decode_isolation();
		logic [31:0] d;
		test_name = "decode";
		d = rand32();
		// same word offset everywhere, s0 and s1 differ only in bit 29
		bus_write(1'b0, mem_addr(2, d[7:0], 19'h0), d, 4'hf);
		bus_write(1'b0, mem_addr(3, d[7:0], 19'h0), ~d, 4'hf);
		bus_write(1'b0, mem_addr(0, d[7:0], 19'h0), d ^ 32'h5a5a_5a5a, 4'hf);
		bus_write(1'b0, mem_addr(1, d[7:0], 19'h0), d ^ 32'ha5a5_a5a5, 4'hf);
		bus_read(1'b0, mem_addr(2, d[7:0], 19'h0));
		bus_read(1'b0, mem_addr(3, d[7:0], 19'h0));
		bus_read(1'b0, mem_addr(0, d[7:0], 19'h0));
		bus_read(1'b0, mem_addr(1, d[7:0], 19'h0));
	endtask

	task automatic sysctl_registers();
		logic [31:0] id_adr;
		logic [31:0] mode_adr;
		logic [31:0] scr_adr;
		test_name = "sysctl";
		id_adr = mem_addr(4, {6'b0, conbus_pkg::REG_ID}, 19'h0);
		mode_adr = mem_addr(4, {6'b0, conbus_pkg::REG_ARB_MODE}, 19'h0);
		scr_adr = mem_addr(4, {6'b0, conbus_pkg::REG_SCRATCH}, 19'h0);
		bus_read(1'b0, id_adr);
		bus_write(1'b0, id_adr, rand32(), 4'hf);
		bus_read(1'b0, id_adr);
		bus_write(1'b0, scr_adr, rand32(), 4'hf);
		bus_read(1'b0, scr_adr);
		// upper bits are noise, only bit 0 is kept
		bus_write(1'b0, mode_adr, rand32() | 32'h1, 4'hf);
		bus_read(1'b0, mode_adr);
		bus_write(1'b0, mode_adr, rand32() & ~32'h1, 4'hf);
		bus_read(1'b0, mode_adr);
	endtask

	// one master's half of the concurrent test, each on its own ram
	task automatic master_stream(input bit port);
		int s;
		logic [31:0] adr;
		logic [3:0] sel;
		s = port ? 3 : 2;
		for (int i = 0; i < CONC_OPS; i++) begin
			adr = mem_addr(s, c_word[port][i], 19'h0);
			sel = ref_written[s][c_word[port][i]] ? c_sel[port][i] : 4'hf;
			bus_write(port, adr, c_dat[port][i], sel);
			// let go of cyc so the other master gets a turn
			wb_idle(port, 1);
			bus_read(port, adr);
			wb_idle(port, 1);
		end
	endtask

	task automatic concurrent_masters();
		logic [31:0] r;
		test_name = "concurrent";
		for (int p = 0; p < 2; p++) begin
			for (int i = 0; i < CONC_OPS; i++) begin
				r = rand32();
				// few words, so some get partial rewrites
				c_word[p][i] = {4'h0, r[3:0]};
				c_sel[p][i] = r[7:4];
				c_dat[p][i] = rand32();
			end
		end
		fork
			master_stream(1'b0);
			master_stream(1'b1);
		join
	endtask

	// both masters ask in the same cycle from idle
	task automatic race_pair(input logic [31:0] a0, input logic [31:0] a1);
		bit exp_first;
		last_owner = ack_order[ack_order.size() - 1];
		exp_first = first_grant(ref_mode, last_owner);
		ack_order.delete();
		fork
			bus_read(1'b0, a0);
			bus_read(1'b1, a1);
		join
		assert (ack_order.size() == 2) else show_problem("race did not give one ack per master");
		assert (ack_order[0] == exp_first) else show_mismatch(test_name, exp_first, ack_order[0]);
	endtask

	task automatic arbitration_order();
		logic [31:0] id_adr;
		logic [31:0] mode_adr;
		logic [31:0] scr_adr;
		id_adr = mem_addr(4, {6'b0, conbus_pkg::REG_ID}, 19'h0);
		mode_adr = mem_addr(4, {6'b0, conbus_pkg::REG_ARB_MODE}, 19'h0);
		scr_adr = mem_addr(4, {6'b0, conbus_pkg::REG_SCRATCH}, 19'h0);
		test_name = "arb fixed";
		bus_write(1'b0, mode_adr, {31'b0, conbus_pkg::ARB_FIXED_M0}, 4'hf);
		for (int i = 0; i < FIXED_ROUNDS; i++) begin
			// m0 held last, only the fixed rule puts it first
			bus_read(1'b0, scr_adr);
			wb_idle(1'b0, 2);
			race_pair(id_adr, scr_adr);
			wb_idle(1'b0, 2);
		end
		test_name = "arb round robin";
		bus_write(1'b0, mode_adr, {31'b0, conbus_pkg::ARB_ROUND_ROBIN}, 4'hf);
		wb_idle(1'b0, 2);
		// m1 asks a cycle late and waits for m0 to let go
		fork
			bus_read(1'b0, id_adr);
			begin
				wb_idle(1'b1, 1);
				bus_read(1'b1, scr_adr);
			end
		join
		wb_idle(1'b0, 2);
		race_pair(id_adr, scr_adr);
		bus_read(1'b0, scr_adr);
		wb_idle(1'b0, 2);
		race_pair(id_adr, scr_adr);
	endtask

	// watchdog, budget per planned access plus reset
	initial begin
		#((RESET_CYCLES + 200 * PLANNED) * CLK_PERIOD);
		show_problem("bus hung, an access got no ack in time");
	end

	initial begin
		seed = 32'h07c0_57c9;
		sys_clk = 1'b0;
		rst_i = 1'b1;
		wb_drive(1'b0, 1'b0, 1'b0, '0, '0, '0);
		wb_drive(1'b1, 1'b0, 1'b0, '0, '0, '0);
		repeat (RESET_CYCLES) @(posedge sys_clk);
		#10;
		rst_i = 1'b0;
		memory_readback();
		decode_isolation();
		sysctl_registers();
		concurrent_masters();
		arbitration_order();
		wb_idle(1'b0, 2);
		if (q_port.size() != 0) begin
			show_problem("accesses finished without their ack");
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule
